//--- list.f
+incdir+.
pcr_stream_pkg.sv
pcr_desc_pkg.sv
pcr_slot_table.sv
pcr_scratch_ram.sv
pcr_slot_reader.sv
pcr_top.sv
tb_pcr_sva.sv
tb_pcr.sv

//--- pcr_desc_pkg.sv
// Request, DMA descriptor and readout record types for the continuous-read engine
`default_nettype none

`include "pcr_macros.svh"

package pcr_desc_pkg;

  // Low destination bits supplied by a core request
  localparam int DEST_LOW_BITS = `PCR_DEST_BITS - `PCR_CORE_ID_BITS;

  typedef logic [`PCR_SLOT_BITS-1:0]      slot_t;
  // Length in beats, 1 to PCR_BEATS_PER_SLOT
  typedef logic [`PCR_BEAT_BITS:0]        len_t;
  typedef logic [`PCR_PCIE_ADDR_BITS-1:0] pcie_addr_t;
  typedef logic [`PCR_CORE_ADDR_BITS-1:0] core_addr_t;
  typedef logic [`PCR_CORE_ID_BITS-1:0]   core_id_t;
  typedef logic [`PCR_DEST_BITS-1:0]      dest_t;
  typedef logic [`PCR_HOST_TAG_BITS-1:0]  host_tag_t;

  typedef struct packed {
    pcie_addr_t pcie_addr;
    core_id_t   core_id;
    core_addr_t core_addr;
    len_t       len;
    host_tag_t  host_tag;
  } host_req_t;

  // Core number travels beside this record
  typedef struct packed {
    pcie_addr_t               pcie_addr;
    core_addr_t               core_addr;
    logic [DEST_LOW_BITS-1:0] dest_low;
    len_t                     len;
  } core_req_t;

  typedef struct packed {
    pcie_addr_t                pcie_addr;
    pcr_stream_pkg::ram_addr_t ram_addr;
    len_t                      len;
    slot_t                     tag;
  } dma_desc_t;

  typedef struct packed {
    slot_t      slot;
    len_t       len;
    dest_t      dest;
    core_addr_t core_addr;
  } readout_t;

endpackage

`default_nettype wire

//--- pcr_macros.svh
// PCIe continuous-read sizing for slots, beats and field widths
`ifndef PCR_MACROS_SVH
`define PCR_MACROS_SVH

// Scratchpad slots and their index width
`define PCR_SLOT_COUNT      4
`define PCR_SLOT_BITS       2
`define PCR_BEATS_PER_SLOT  8
`define PCR_BEAT_BITS       3

// Data and address widths
`define PCR_DATA_BITS       64
`define PCR_PCIE_ADDR_BITS  64
`define PCR_CORE_ADDR_BITS  16
`define PCR_CORE_ID_BITS    4
`define PCR_DEST_BITS       8
`define PCR_HOST_TAG_BITS   8

// Core address position inside the header beat
`define PCR_HDR_ADDR_LSB    32

`endif

//--- pcr_scratch_ram.sv
// Single-port scratchpad shared by DMA writes and readout reads, writes first
`timescale 1ns/1ps
`default_nettype none

`include "pcr_macros.svh"

module pcr_scratch_ram (
  input  wire                            pcie_clk,
  input  wire                            pcie_rst,

  // DMA write side
  input  wire pcr_stream_pkg::ram_wr_t   wr,
  input  wire                            wr_valid,
  output logic                           wr_ready,

  // Readout side
  input  wire pcr_stream_pkg::ram_addr_t rd_addr,
  input  wire                            rd_valid,
  output logic                           rd_ready,

  output pcr_stream_pkg::beat_t          rd_data,
  output logic                           rd_data_valid
);
  import pcr_stream_pkg::*;

  localparam int DEPTH = `PCR_SLOT_COUNT * `PCR_BEATS_PER_SLOT;

  beat_t mem [DEPTH];
  logic  rd_grant;

  // Writes are never stalled
  assign wr_ready = 1'b1;

  // A read only gets the port in a cycle with no write
  assign rd_ready = !wr_valid;
  assign rd_grant = rd_valid && rd_ready;

  always_ff @(posedge pcie_clk) begin
    if (wr_valid) begin
      mem[wr.addr] <= wr.data;
    end
    if (rd_grant) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Read data is valid the cycle after the grant
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      rd_data_valid <= 1'b0;
    end else begin
      rd_data_valid <= rd_grant;
    end
  end

endmodule

`default_nettype wire

//--- pcr_slot_reader.sv
// Slot readout engine that sends a header beat and then the slot data to the cores
`timescale 1ns/1ps
`default_nettype none

`include "pcr_macros.svh"

module pcr_slot_reader (
  input  wire                            pcie_clk,
  input  wire                            pcie_rst,

  input  wire pcr_desc_pkg::readout_t    readout,
  input  wire                            readout_valid,
  output logic                           readout_ready,

  output pcr_stream_pkg::ram_addr_t      rd_addr,
  output logic                           rd_valid,
  input  wire                            rd_ready,

  input  wire pcr_stream_pkg::beat_t     rd_data,
  input  wire                            rd_data_valid,

  output pcr_stream_pkg::stream_beat_t   cores_rx,
  output logic                           cores_rx_valid,
  input  wire                            cores_rx_ready,

  output pcr_desc_pkg::slot_t            done_slot,
  output logic                           done_valid
);
  import pcr_desc_pkg::*;
  import pcr_stream_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_READ,
    ST_WAIT_DATA,
    ST_SEND
  } state_t;

  state_t                    state;
  readout_t                  rec_q;
  logic [`PCR_BEAT_BITS-1:0] beat_idx;
  logic                      final_beat;
  logic                      take_rec;

  assign readout_ready = (state == ST_IDLE);
  assign take_rec      = readout_valid && readout_ready;

  // One read in flight at a time, addressed inside the current slot
  assign rd_valid  = (state == ST_READ);
  assign rd_addr   = {rec_q.slot, beat_idx};
  assign done_slot = rec_q.slot;

  // Beat index counts from zero, length from one
  assign final_beat = (len_t'(beat_idx) + len_t'(1)) == rec_q.len;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state          <= ST_IDLE;
      cores_rx_valid <= 1'b0;
      done_valid     <= 1'b0;
      beat_idx       <= '0;
    end else begin
      done_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (take_rec) begin
            cores_rx_valid <= 1'b1;
            beat_idx       <= '0;
            state          <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (cores_rx_ready) begin
            cores_rx_valid <= 1'b0;
            state          <= ST_READ;
          end
        end
        ST_READ: begin
          if (rd_ready) begin
            state <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA: begin
          if (rd_data_valid) begin
            cores_rx_valid <= 1'b1;
            state          <= ST_SEND;
          end
        end
        ST_SEND: begin
          // Next read waits until the current beat is taken
          if (cores_rx_ready) begin
            cores_rx_valid <= 1'b0;
            if (cores_rx.last) begin
              done_valid <= 1'b1;
              state      <= ST_IDLE;
            end else begin
              beat_idx <= beat_idx + 1'b1;
              state    <= ST_READ;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Output beat and the record being read out
  always_ff @(posedge pcie_clk) begin
    if (take_rec) begin
      rec_q         <= readout;
      // Header carries only the core address
      cores_rx.data <= beat_t'(readout.core_addr) << `PCR_HDR_ADDR_LSB;
      cores_rx.dest <= readout.dest;
      cores_rx.last <= 1'b0;
    end else if (state == ST_WAIT_DATA && rd_data_valid) begin
      cores_rx.data <= rd_data;
      cores_rx.last <= final_beat;
    end
  end

endmodule

`default_nettype wire

//--- pcr_slot_table.sv
// Slot table that allocates slots, issues DMA descriptors and queues finished reads
`timescale 1ns/1ps
`default_nettype none

`include "pcr_macros.svh"

module pcr_slot_table (
  input  wire                       pcie_clk,
  input  wire                       pcie_rst,

  input  wire pcr_desc_pkg::host_req_t host_req,
  input  wire                       host_req_valid,
  output logic                      host_req_ready,

  input  wire pcr_desc_pkg::core_req_t core_req,
  input  wire pcr_desc_pkg::core_id_t  core_id,
  input  wire                       core_req_valid,
  output logic                      core_req_ready,

  output pcr_desc_pkg::dma_desc_t   dma_desc,
  output logic                      dma_desc_valid,
  input  wire                       dma_desc_ready,

  input  wire pcr_desc_pkg::slot_t  dma_status_tag,
  input  wire                       dma_status_valid,

  output pcr_desc_pkg::readout_t    readout,
  output logic                      readout_valid,
  input  wire                       readout_ready,

  input  wire pcr_desc_pkg::slot_t  done_slot,
  input  wire                       done_valid,

  output pcr_desc_pkg::host_tag_t   host_status_tag,
  output logic                      host_status_valid
);
  import pcr_desc_pkg::*;
  import pcr_stream_pkg::*;

  localparam int SLOTS     = `PCR_SLOT_COUNT;
  localparam int SLOT_BITS = `PCR_SLOT_BITS;

  logic [SLOTS-1:0] slot_free;
  logic [SLOTS-1:0] take_mask;
  logic [SLOTS-1:0] release_mask;
  slot_t            sel_slot;
  ram_addr_t        slot_base;
  logic             any_free;
  logic             desc_space;
  logic             host_acc;
  logic             core_acc;
  logic             req_acc;

  // Per-slot bookkeeping, valid while the slot is outstanding
  len_t       slot_len       [SLOTS];
  dest_t      slot_dest      [SLOTS];
  core_addr_t slot_core_addr [SLOTS];
  host_tag_t  slot_host_tag  [SLOTS];

  // Completion stage and readout queue of slot numbers
  slot_t              stat_tag_q;
  logic               stat_valid_q;
  slot_t              fifo_mem [SLOTS];
  logic [SLOT_BITS:0] wr_ptr;
  logic [SLOT_BITS:0] rd_ptr;
  slot_t              head_slot;

  // Lowest-numbered free slot wins
  always_comb begin
    sel_slot = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (slot_free[i]) begin
        sel_slot = slot_t'(i);
      end
    end
  end

  assign any_free   = |slot_free;
  assign slot_base  = {sel_slot, {`PCR_BEAT_BITS{1'b0}}};
  // Descriptor register is empty or drains this cycle
  assign desc_space = !dma_desc_valid || dma_desc_ready;

  // Host has priority, cores wait while the host is asking
  assign host_req_ready = any_free && desc_space;
  assign core_req_ready = any_free && desc_space && !host_req_valid;
  assign host_acc       = host_req_valid && host_req_ready;
  assign core_acc       = core_req_valid && core_req_ready;
  assign req_acc        = host_acc || core_acc;

  assign take_mask    = req_acc ? (SLOTS'(1) << sel_slot) : '0;
  assign release_mask = done_valid ? (SLOTS'(1) << done_slot) : '0;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      slot_free         <= '1;
      dma_desc_valid    <= 1'b0;
      stat_valid_q      <= 1'b0;
      wr_ptr            <= '0;
      rd_ptr            <= '0;
      host_status_valid <= 1'b0;
    end else begin
      slot_free    <= (slot_free & ~take_mask) | release_mask;
      stat_valid_q <= dma_status_valid;
      if (req_acc) begin
        dma_desc_valid <= 1'b1;
      end else if (dma_desc_ready) begin
        dma_desc_valid <= 1'b0;
      end
      if (stat_valid_q) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (readout_valid && readout_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Only host requests with a real tag report back
      host_status_valid <= done_valid && (slot_host_tag[done_slot] != '0);
    end
  end

  // Request bookkeeping and descriptor contents
  always_ff @(posedge pcie_clk) begin
    if (host_acc) begin
      slot_len[sel_slot]       <= host_req.len;
      slot_dest[sel_slot]      <= {host_req.core_id, {DEST_LOW_BITS{1'b0}}};
      slot_core_addr[sel_slot] <= host_req.core_addr;
      slot_host_tag[sel_slot]  <= host_req.host_tag;
    end else if (core_acc) begin
      slot_len[sel_slot]       <= core_req.len;
      slot_dest[sel_slot]      <= {core_id, core_req.dest_low};
      slot_core_addr[sel_slot] <= core_req.core_addr;
      slot_host_tag[sel_slot]  <= '0;
    end
    if (req_acc) begin
      dma_desc.pcie_addr <= host_acc ? host_req.pcie_addr : core_req.pcie_addr;
      dma_desc.ram_addr  <= slot_base;
      dma_desc.len       <= host_acc ? host_req.len : core_req.len;
      dma_desc.tag       <= sel_slot;
    end
  end

  // Completions queue in arrival order, at most one per outstanding slot
  always_ff @(posedge pcie_clk) begin
    stat_tag_q <= dma_status_tag;
    if (stat_valid_q) begin
      fifo_mem[wr_ptr[SLOT_BITS-1:0]] <= stat_tag_q;
    end
    if (done_valid) begin
      host_status_tag <= slot_host_tag[done_slot];
    end
  end

  assign head_slot     = fifo_mem[rd_ptr[SLOT_BITS-1:0]];
  assign readout_valid = (wr_ptr != rd_ptr);

  // Readout record built from the head slot's bookkeeping
  always_comb begin
    readout.slot      = head_slot;
    readout.len       = slot_len[head_slot];
    readout.dest      = slot_dest[head_slot];
    readout.core_addr = slot_core_addr[head_slot];
  end

endmodule

`default_nettype wire

//--- pcr_stream_pkg.sv
// Scratchpad access and core output stream types for the continuous-read engine
`default_nettype none

`include "pcr_macros.svh"

package pcr_stream_pkg;

  // Slot index sits above the beat index
  typedef logic [`PCR_SLOT_BITS+`PCR_BEAT_BITS-1:0] ram_addr_t;

  typedef logic [`PCR_DATA_BITS-1:0] beat_t;

  // One scratchpad write from the DMA engine
  typedef struct packed {
    ram_addr_t addr;
    beat_t     data;
  } ram_wr_t;

  // One beat on the stream to the cores
  typedef struct packed {
    beat_t                     data;
    logic [`PCR_DEST_BITS-1:0] dest;
    logic                      last;
  } stream_beat_t;

endpackage

`default_nettype wire

//--- pcr_top.sv
// PCIe continuous-read engine top joining the slot table, scratchpad and reader
`timescale 1ns/1ps
`default_nettype none

module pcr_top (
  input  wire                                pcie_clk,
  input  wire                                pcie_rst,

  // Host read requests and status
  input  wire pcr_desc_pkg::host_req_t       host_req,
  input  wire                                host_req_valid,
  output wire                                host_req_ready,
  output wire pcr_desc_pkg::host_tag_t       host_status_tag,
  output wire                                host_status_valid,

  // Core read requests
  input  wire pcr_desc_pkg::core_req_t       core_req,
  input  wire pcr_desc_pkg::core_id_t        core_id,
  input  wire                                core_req_valid,
  output wire                                core_req_ready,

  // External PCIe DMA engine
  output wire pcr_desc_pkg::dma_desc_t       dma_desc,
  output wire                                dma_desc_valid,
  input  wire                                dma_desc_ready,
  input  wire pcr_desc_pkg::slot_t           dma_status_tag,
  input  wire                                dma_status_valid,
  input  wire pcr_stream_pkg::ram_wr_t       dma_wr,
  input  wire                                dma_wr_valid,
  output wire                                dma_wr_ready,

  // Data stream to the cores
  output wire pcr_stream_pkg::stream_beat_t  cores_rx,
  output wire                                cores_rx_valid,
  input  wire                                cores_rx_ready
);
  import pcr_desc_pkg::*;
  import pcr_stream_pkg::*;

  readout_t  readout;
  logic      readout_valid;
  logic      readout_ready;
  slot_t     done_slot;
  logic      done_valid;
  ram_addr_t rd_addr;
  logic      rd_valid;
  logic      rd_ready;
  beat_t     rd_data;
  logic      rd_data_valid;

  pcr_slot_table u_table (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .host_req          (host_req),
    .host_req_valid    (host_req_valid),
    .host_req_ready    (host_req_ready),
    .core_req          (core_req),
    .core_id           (core_id),
    .core_req_valid    (core_req_valid),
    .core_req_ready    (core_req_ready),
    .dma_desc          (dma_desc),
    .dma_desc_valid    (dma_desc_valid),
    .dma_desc_ready    (dma_desc_ready),
    .dma_status_tag    (dma_status_tag),
    .dma_status_valid  (dma_status_valid),
    .readout           (readout),
    .readout_valid     (readout_valid),
    .readout_ready     (readout_ready),
    .done_slot         (done_slot),
    .done_valid        (done_valid),
    .host_status_tag   (host_status_tag),
    .host_status_valid (host_status_valid)
  );

  // DMA writes land directly on the scratchpad write side
  pcr_scratch_ram u_ram (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .wr            (dma_wr),
    .wr_valid      (dma_wr_valid),
    .wr_ready      (dma_wr_ready),
    .rd_addr       (rd_addr),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

  pcr_slot_reader u_reader (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .readout        (readout),
    .readout_valid  (readout_valid),
    .readout_ready  (readout_ready),
    .rd_addr        (rd_addr),
    .rd_valid       (rd_valid),
    .rd_ready       (rd_ready),
    .rd_data        (rd_data),
    .rd_data_valid  (rd_data_valid),
    .cores_rx       (cores_rx),
    .cores_rx_valid (cores_rx_valid),
    .cores_rx_ready (cores_rx_ready),
    .done_slot      (done_slot),
    .done_valid     (done_valid)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the continuous-read engine testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --assert --top-module tb_pcr -f list.f -o tb_pcr_sim \
  && ./obj_dir/tb_pcr_sim | tee /dev/stderr | grep -qx "Result: PASSED" \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

//--- tb_pcr.sv
// Testbench for the PCIe continuous-read engine with a DMA model and a scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "pcr_macros.svh"

module tb_pcr;
  import pcr_desc_pkg::*;
  import pcr_stream_pkg::*;

  localparam int TIMEOUT = 2000;

  // What the DUT should have recorded for one request
  typedef struct packed {
    pcie_addr_t pcie_addr;
    len_t       len;
    core_addr_t core_addr;
    dest_t      dest;
    host_tag_t  host_tag;
  } exp_req_t;

  logic         pcie_clk = 1'b0;
  logic         pcie_rst;
  host_req_t    host_req;
  logic         host_req_valid;
  logic         host_req_ready;
  host_tag_t    host_status_tag;
  logic         host_status_valid;
  core_req_t    core_req;
  core_id_t     core_id;
  logic         core_req_valid;
  logic         core_req_ready;
  dma_desc_t    dma_desc;
  logic         dma_desc_valid;
  logic         dma_desc_ready = 1'b0;
  slot_t        dma_status_tag;
  logic         dma_status_valid;
  ram_wr_t      dma_wr;
  logic         dma_wr_valid;
  logic         dma_wr_ready;
  stream_beat_t cores_rx;
  logic         cores_rx_valid;
  logic         cores_rx_ready = 1'b0;

  logic [31:0]                lfsr = 32'hbbfd_a1c1;
  beat_t                      sb [`PCR_SLOT_COUNT * `PCR_BEATS_PER_SLOT];
  exp_req_t                   slot_info [`PCR_SLOT_COUNT];
  logic [`PCR_SLOT_COUNT-1:0] busy = '0;
  exp_req_t                   req_q [$];
  slot_t                      pend_q [$];
  slot_t                      comp_q [$];
  int                         beat_pos = 0;
  logic                       stat_q1 = 1'b0;
  logic                       stat_q2 = 1'b0;
  host_tag_t                  stat_tag_q1 = '0;
  host_tag_t                  stat_tag_q2 = '0;
  int                         errors = 0;
  int                         timeouts = 0;
  int                         readouts = 0;
  int                         reqs = 0;
  int                         cyc = 0;

  pcr_top u_dut (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .host_req          (host_req),
    .host_req_valid    (host_req_valid),
    .host_req_ready    (host_req_ready),
    .host_status_tag   (host_status_tag),
    .host_status_valid (host_status_valid),
    .core_req          (core_req),
    .core_id           (core_id),
    .core_req_valid    (core_req_valid),
    .core_req_ready    (core_req_ready),
    .dma_desc          (dma_desc),
    .dma_desc_valid    (dma_desc_valid),
    .dma_desc_ready    (dma_desc_ready),
    .dma_status_tag    (dma_status_tag),
    .dma_status_valid  (dma_status_valid),
    .dma_wr            (dma_wr),
    .dma_wr_valid      (dma_wr_valid),
    .dma_wr_ready      (dma_wr_ready),
    .cores_rx          (cores_rx),
    .cores_rx_valid    (cores_rx_valid),
    .cores_rx_ready    (cores_rx_ready)
  );

  always #4 pcie_clk = ~pcie_clk;

  // Fixed stall patterns on the DMA descriptor port and the core stream
  always @(posedge pcie_clk) begin
    #1;
    cyc            = cyc + 1;
    dma_desc_ready = (cyc % 3) != 0;
    cores_rx_ready = (cyc % 7) < 4;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic host_req_t rand_host(input logic with_tag);
    host_req_t r;
    r.pcie_addr = lfsr_bits(64);
    r.core_id   = core_id_t'(lfsr_bits(4));
    r.core_addr = core_addr_t'(lfsr_bits(16));
    r.len       = len_t'(lfsr_bits(3)) + len_t'(1);
    r.host_tag  = with_tag ? host_tag_t'(lfsr_bits(7)) + host_tag_t'(1) : '0;
    return r;
  endfunction

  function automatic core_req_t rand_core();
    core_req_t r;
    r.pcie_addr = lfsr_bits(64);
    r.core_addr = core_addr_t'(lfsr_bits(16));
    r.dest_low  = DEST_LOW_BITS'(lfsr_bits(DEST_LOW_BITS));
    r.len       = len_t'(lfsr_bits(3)) + len_t'(1);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want) else begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic send_host(input host_req_t req);
    int t;
    host_req       = req;
    host_req_valid = 1'b1;
    for (t = 0; t < TIMEOUT; t++) begin
      @(posedge pcie_clk);
      if (host_req_ready) break;
    end
    if (t == TIMEOUT) begin
      timeouts++;
      $display("Timeout: host request was never accepted");
    end else begin
      req_q.push_back({req.pcie_addr, req.len, req.core_addr,
                       {req.core_id, {DEST_LOW_BITS{1'b0}}}, req.host_tag});
      reqs++;
    end
    #1;
    host_req_valid = 1'b0;
  endtask

  task automatic send_core(input core_req_t req, input core_id_t id);
    int t;
    core_req       = req;
    core_id        = id;
    core_req_valid = 1'b1;
    for (t = 0; t < TIMEOUT; t++) begin
      @(posedge pcie_clk);
      if (core_req_ready) break;
    end
    if (t == TIMEOUT) begin
      timeouts++;
      $display("Timeout: core request was never accepted");
    end else begin
      req_q.push_back({req.pcie_addr, req.len, req.core_addr, {id, req.dest_low},
                       host_tag_t'(0)});
      reqs++;
    end
    #1;
    core_req_valid = 1'b0;
  endtask

  task automatic wait_pending(input int n);
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      if (pend_q.size() >= n) break;
      @(posedge pcie_clk);
      #1;
    end
    if (t == TIMEOUT) begin
      timeouts++;
      $display("Timeout while waiting for %0d descriptors from the DUT", n);
    end
  endtask

  // DMA model: fill the slot of one pending descriptor, then report it done
  task automatic complete_one(input int idx);
    slot_t tag;
    beat_t data;
    int    b;
    int    t;
    wait_pending(idx + 1);
    if (pend_q.size() > idx) begin
      tag = pend_q[idx];
      pend_q.delete(idx);
      for (b = 0; b < int'(slot_info[tag].len); b++) begin
        data                = lfsr_bits(64);
        sb[{tag, 3'(b)}]    = data;
        dma_wr.addr         = {tag, 3'(b)};
        dma_wr.data         = data;
        dma_wr_valid        = 1'b1;
        for (t = 0; t < TIMEOUT; t++) begin
          @(posedge pcie_clk);
          if (dma_wr_ready) break;
        end
        if (t == TIMEOUT) begin
          timeouts++;
          $display("Timeout: scratchpad never took a DMA write");
        end
        #1;
      end
      dma_wr_valid     = 1'b0;
      dma_status_tag   = tag;
      dma_status_valid = 1'b1;
      @(posedge pcie_clk);
      comp_q.push_back(tag);
      #1;
      dma_status_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      if (comp_q.size() == 0 && pend_q.size() == 0 && req_q.size() == 0) break;
      @(posedge pcie_clk);
      #1;
    end
    if (t == TIMEOUT) begin
      timeouts++;
      $display("Timeout: readouts did not drain");
    end
    repeat (4) @(posedge pcie_clk);
    #1;
  endtask

  // Descriptor capture, readout scoreboard and host status check
  always @(posedge pcie_clk) begin : monitor
    exp_req_t want;
    exp_req_t info;
    slot_t    tag;
    slot_t    slot;
    logic     fin;
    fin = 1'b0;
    if (pcie_rst) begin
      beat_pos = 0;
    end else begin
      check_value("host_status_valid", 64'(host_status_valid), 64'(stat_q2));
      if (stat_q2) begin
        check_value("host_status_tag", 64'(host_status_tag), 64'(stat_tag_q2));
      end
      if (dma_desc_valid && dma_desc_ready) begin
        tag = dma_desc.tag;
        if (req_q.size() == 0) begin
          errors++;
          $display("Descriptor issued with no accepted request behind it");
        end else begin
          want = req_q.pop_front();
          check_value("dma_desc.pcie_addr", dma_desc.pcie_addr, want.pcie_addr);
          check_value("dma_desc.len", 64'(dma_desc.len), 64'(want.len));
          check_value("dma_desc.ram_addr", 64'(dma_desc.ram_addr), 64'(tag) * 64'd8);
          assert (!busy[tag]) else begin
            errors++;
            $display("Descriptor tag %0d is already held by an outstanding read", tag);
          end
          slot_info[tag] = want;
          busy[tag]     <= 1'b1;
          pend_q.push_back(tag);
        end
      end
      if (cores_rx_valid && cores_rx_ready) begin
        if (comp_q.size() == 0) begin
          errors++;
          $display("Beat on cores_rx with no completed slot waiting");
        end else begin
          slot = comp_q[0];
          info = slot_info[slot];
          check_value("cores_rx.dest", 64'(cores_rx.dest), 64'(info.dest));
          if (beat_pos == 0) begin
            check_value("cores_rx.data", cores_rx.data,
                        64'(info.core_addr) << `PCR_HDR_ADDR_LSB);
            check_value("cores_rx.last", 64'(cores_rx.last), 64'd0);
          end else begin
            check_value("cores_rx.data", cores_rx.data, sb[{slot, 3'(beat_pos - 1)}]);
            check_value("cores_rx.last", 64'(cores_rx.last),
                        64'(beat_pos == int'(info.len)));
          end
          if (beat_pos == int'(info.len)) begin
            fin = 1'b1;
            void'(comp_q.pop_front());
            busy[slot] <= 1'b0;
            beat_pos    = 0;
            readouts++;
          end else begin
            beat_pos++;
          end
        end
      end
    end
    // Status shows two edges after the final beat
    stat_q1     <= fin && (info.host_tag != '0);
    stat_tag_q1 <= info.host_tag;
    stat_q2     <= stat_q1;
    stat_tag_q2 <= stat_tag_q1;
  end

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    host_req_valid |-> !core_req_ready)
    else begin
      errors++;
      $display("Core request was ready while a host request was waiting");
    end

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    (&busy) |-> (!host_req_ready && !core_req_ready))
    else begin
      errors++;
      $display("A request was ready while all slots were outstanding");
    end

  // Stalled beat on the core stream holds until the cores take it
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    cores_rx_valid && !cores_rx_ready |=> cores_rx_valid && $stable(cores_rx))
    else begin
      errors++;
      $display("Core stream beat changed or dropped while the cores stalled");
    end

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    dma_wr_valid |-> dma_wr_ready)
    else begin
      errors++;
      $display("Scratchpad refused a DMA write");
    end

  initial begin : main_flow
    host_req_t hreq;
    core_req_t creq;
    core_id_t  cid;
    int        i;
    pcie_rst         = 1'b1;
    host_req         = '0;
    host_req_valid   = 1'b0;
    core_req         = '0;
    core_id          = '0;
    core_req_valid   = 1'b0;
    dma_status_tag   = '0;
    dma_status_valid = 1'b0;
    dma_wr           = '0;
    dma_wr_valid     = 1'b0;
    repeat (4) @(posedge pcie_clk);
    #1;
    pcie_rst = 1'b0;

    // Single core reads, one at a time
    for (i = 0; i < 3; i++) begin
      creq = rand_core();
      send_core(creq, core_id_t'(lfsr_bits(4)));
      complete_one(0);
      wait_idle();
    end

    // Host and core ask together, completions come back out of order
    hreq = rand_host(1'b1);
    creq = rand_core();
    cid  = core_id_t'(lfsr_bits(4));
    fork
      send_host(hreq);
      send_core(creq, cid);
    join
    complete_one(1);
    complete_one(0);
    wait_idle();

    // Host tag zero
    send_host(rand_host(1'b0));
    complete_one(0);
    wait_idle();

    // All slots taken, a host request waits until one readout ends
    for (i = 0; i < 4; i++) begin
      creq = rand_core();
      send_core(creq, core_id_t'(lfsr_bits(4)));
    end
    wait_pending(4);
    hreq = rand_host(1'b1);
    fork
      send_host(hreq);
      begin
        repeat (6) @(posedge pcie_clk);
        #1;
        complete_one(2);
      end
    join
    for (i = 0; i < 4; i++) begin
      complete_one(0);
    end
    wait_idle();

    check_value("readouts", 64'(readouts), 64'(reqs));
    $display("Checks finished with %0d errors and %0d timeouts over %0d readouts",
             errors, timeouts, readouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_pcr_sva.sv
// Handshake stability and reset checks bound onto the continuous-read top level
`timescale 1ns/1ps
`default_nettype none

module tb_pcr_sva (
  input wire                               pcie_clk,
  input wire                               pcie_rst,
  input wire pcr_desc_pkg::dma_desc_t      dma_desc,
  input wire                               dma_desc_valid,
  input wire                               dma_desc_ready,
  input wire pcr_stream_pkg::stream_beat_t cores_rx,
  input wire                               cores_rx_valid,
  input wire                               cores_rx_ready,
  input wire pcr_desc_pkg::readout_t       readout,
  input wire                               readout_valid,
  input wire                               readout_ready,
  input wire pcr_stream_pkg::ram_addr_t    rd_addr,
  input wire                               rd_valid,
  input wire                               rd_ready,
  input wire                               rd_data_valid,
  input wire                               done_valid,
  input wire                               host_status_valid
);

  // Payload holds while the receiver stalls
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    dma_desc_valid && !dma_desc_ready |=> dma_desc_valid && $stable(dma_desc))
    else $error("DMA descriptor changed or dropped while waiting for ready");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    cores_rx_valid && !cores_rx_ready |=> cores_rx_valid && $stable(cores_rx))
    else $error("Core stream beat changed or dropped while waiting for ready");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    readout_valid && !readout_ready |=> readout_valid && $stable(readout))
    else $error("Readout record changed or dropped while the reader was busy");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
    else $error("Scratchpad read address moved while the read was not granted");

  // Granted read returns data one cycle later
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_valid && rd_ready |=> rd_data_valid)
    else $error("Scratchpad read data did not follow a granted read");

  assert property (@(posedge pcie_clk)
    $past(pcie_rst) |-> !dma_desc_valid && !readout_valid && !cores_rx_valid
                        && !done_valid && !rd_valid && !host_status_valid)
    else $error("A valid output was high right after reset");

endmodule

bind pcr_top tb_pcr_sva u_sva (
  .pcie_clk          (pcie_clk),
  .pcie_rst          (pcie_rst),
  .dma_desc          (dma_desc),
  .dma_desc_valid    (dma_desc_valid),
  .dma_desc_ready    (dma_desc_ready),
  .cores_rx          (cores_rx),
  .cores_rx_valid    (cores_rx_valid),
  .cores_rx_ready    (cores_rx_ready),
  .readout           (readout),
  .readout_valid     (readout_valid),
  .readout_ready     (readout_ready),
  .rd_addr           (rd_addr),
  .rd_valid          (rd_valid),
  .rd_ready          (rd_ready),
  .rd_data_valid     (rd_data_valid),
  .done_valid        (done_valid),
  .host_status_valid (host_status_valid)
);

`default_nettype wire
